// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = gnn_aggr_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+rtl
rtl/gnn_pkg.sv
rtl/pe_bank_if.sv
rtl/task_decode.sv
rtl/neighbor_table.sv
rtl/feature_table.sv
rtl/edge_pe.sv
rtl/aggregation_bank.sv
rtl/gnn_aggr_top.sv
verification/gnn_aggr_tb.sv

// File: rtl/aggregation_bank.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module aggregation_bank (
    input  logic              clk,
    input  logic              reset,
    pe_bank_if.bank           bank,
    input  logic              prev_rd,
    output logic              prev_valid,
    output gnn_pkg::agg_vec_t prev_data,
    output logic              result_valid,
    output gnn_pkg::node_id_t result_node,
    output gnn_pkg::agg_vec_t result_sum
);
    import gnn_pkg::*;

    agg_vec_t acc;
    agg_vec_t out_table [`GNN_NUM_NODES];
    logic     in_stream;
    logic     beat;

    // middle beats carry neither marker
    assign beat = bank.sos || bank.eos || in_stream;

    always_ff @(posedge clk) begin
        if (reset)
            in_stream <= 1'b0;
        else if (bank.eos)
            in_stream <= 1'b0;
        else if (bank.sos)
            in_stream <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            for (int l = 0; l < `GNN_FV_LANES; l++) begin
                acc[l] <= (bank.sos ? '0 : acc[l]) + bank.fv_data[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < `GNN_NUM_NODES; n++) begin
                out_table[n] <= '0;
            end
        end else if (bank.done_aggr || bank.wb_en) begin
            out_table[bank.node_id] <= acc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            prev_valid   <= 1'b0;
        end else begin
            result_valid <= bank.done_aggr;   // write-back stores but does not report
            prev_valid   <= prev_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (bank.done_aggr) begin
            result_node <= bank.node_id;
            result_sum  <= acc;
        end
        if (prev_rd)
            prev_data <= out_table[bank.node_id];
    end

endmodule

// File: rtl/edge_pe.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module edge_pe (
    input  logic               clk,
    input  logic               reset,
    input  logic               task_ready,
    input  gnn_pkg::node_id_t  target,
    input  logic               include_prev,
    input  logic               requeue,
    output logic               take,
    output logic               nbr_rd,
    output gnn_pkg::node_id_t  nbr_rd_node,
    input  logic               nbr_sos,
    input  logic               nbr_eos,
    input  gnn_pkg::nbr_pair_t nbr_pair,
    input  gnn_pkg::degree_t   nbr_degree,
    output logic               fv_rd,
    output gnn_pkg::node_id_t  fv_rd_node,
    input  logic               fv_valid,
    input  gnn_pkg::fv_vec_t   fv_beat,
    output logic               prev_rd,
    input  logic               prev_valid,
    input  gnn_pkg::agg_vec_t  prev_data,
    input  logic               wb_grant,
    output logic               wb_valid,
    pe_bank_if.pe              bank
);
    import gnn_pkg::*;

    edge_state_t state;
    edge_state_t nx_state;
    nbr_ids_t    ids;
    degree_t     degree_q;
    logic [1:0]  pair_cnt;
    degree_t     rd_cnt;     // feature reads issued
    degree_t     fwd_cnt;    // feature beats forwarded
    logic        rd_last;
    logic        fwd_last;

    assign rd_last     = (rd_cnt + 4'd1) >= degree_q;
    assign fwd_last    = (fwd_cnt + 4'd1) >= degree_q;
    assign nbr_rd_node = target;
    assign fv_rd_node  = ids[rd_cnt[2:0]];

    // reads are issued back to back, so beats reach the bank without gaps
    assign bank.node_id = target;
    assign bank.sos     = fv_valid && (fwd_cnt == '0);
    assign bank.eos     = (fv_valid && fwd_last && !include_prev) || prev_valid;

    always_comb begin
        for (int l = 0; l < `GNN_FV_LANES; l++) begin
            bank.fv_data[l] = prev_valid ? prev_data[l] : agg_lane_t'(fv_beat[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= st_idle;
        else
            state <= nx_state;
    end

    always_ff @(posedge clk) begin
        if (reset || state == st_idle) begin
            pair_cnt <= '0;
            rd_cnt   <= '0;
            fwd_cnt  <= '0;
        end else begin
            if (state == st_stream_nbr)
                pair_cnt <= pair_cnt + 2'd1;
            if (fv_rd)
                rd_cnt <= rd_cnt + 4'd1;
            if (fv_valid)
                fwd_cnt <= fwd_cnt + 4'd1;
        end
    end

    // neighbor ids arrive two per beat
    always_ff @(posedge clk) begin
        if (state == st_stream_nbr) begin
            ids[{pair_cnt, 1'b0}] <= nbr_pair[0];
            ids[{pair_cnt, 1'b1}] <= nbr_pair[1];
            if (nbr_sos)
                degree_q <= nbr_degree;
        end
    end

    always_comb begin
        nx_state       = state;
        take           = 1'b0;
        nbr_rd         = 1'b0;
        fv_rd          = 1'b0;
        prev_rd        = 1'b0;
        wb_valid       = 1'b0;
        bank.done_aggr = 1'b0;
        bank.wb_en     = 1'b0;
        case (state)
            st_idle: begin
                if (task_ready) begin
                    take     = 1'b1;
                    nx_state = st_req_nbr;
                end
            end
            st_req_nbr: begin
                nbr_rd   = 1'b1;
                nx_state = st_stream_nbr;
            end
            st_stream_nbr: begin
                if (nbr_eos)
                    nx_state = st_fetch_fv;
            end
            st_fetch_fv: begin
                fv_rd = 1'b1;
                if (rd_last)
                    nx_state = include_prev ? st_req_prev : st_drain;
            end
            st_req_prev: begin
                prev_rd  = 1'b1;    // reads the stored output of target
                nx_state = st_drain;
            end
            st_drain: begin
                if (bank.eos)
                    nx_state = st_finish;
            end
            st_finish: begin
                if (requeue) begin
                    bank.wb_en = 1'b1;
                    nx_state   = st_complete;
                end else begin
                    bank.done_aggr = 1'b1;
                    take           = 1'b1;
                    nx_state       = st_idle;
                end
            end
            st_complete: begin
                wb_valid = 1'b1;   // held until granted
                if (wb_grant) begin
                    take     = 1'b1;
                    nx_state = st_idle;
                end
            end
            default: nx_state = st_idle;
        endcase
    end

endmodule

// File: rtl/feature_table.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module feature_table (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  gnn_pkg::node_id_t wr_node,
    input  gnn_pkg::fv_vec_t  wr_data,
    input  logic              rd,
    input  gnn_pkg::node_id_t rd_node,
    output logic              fv_valid,
    output gnn_pkg::fv_vec_t  fv_data
);
    import gnn_pkg::*;

    fv_vec_t mem [`GNN_NUM_NODES];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_node] <= wr_data;
    end

    // registered read with data one cycle after rd
    always_ff @(posedge clk) begin
        if (rd)
            fv_data <= mem[rd_node];
    end

    always_ff @(posedge clk) begin
        if (reset)
            fv_valid <= 1'b0;
        else
            fv_valid <= rd;
    end

endmodule

// File: rtl/gnn_aggr_top.sv
`timescale 1ns/1ps

module gnn_aggr_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  task_valid,
    input  gnn_pkg::task_packet_t task_packet,
    input  gnn_pkg::replay_iter_t cur_replay_iter,
    output logic                  task_idle,
    input  logic                  nbr_wr_en,
    input  gnn_pkg::node_id_t     nbr_wr_node,
    input  gnn_pkg::degree_t      nbr_wr_degree,
    input  gnn_pkg::nbr_ids_t     nbr_wr_ids,
    input  logic                  fv_wr_en,
    input  gnn_pkg::node_id_t     fv_wr_node,
    input  gnn_pkg::fv_vec_t      fv_wr_data,
    output logic                  result_valid,
    output gnn_pkg::node_id_t     result_node,
    output gnn_pkg::agg_vec_t     result_sum,
    output logic                  wb_valid,
    output gnn_pkg::task_packet_t wb_packet,
    input  logic                  wb_grant
);
    import gnn_pkg::*;

    logic         task_ready;
    node_id_t     target;
    task_packet_t task_word;
    logic         include_prev;
    logic         requeue;
    logic         take;
    logic         nbr_rd;
    node_id_t     nbr_rd_node;
    logic         nbr_sos;
    logic         nbr_eos;
    nbr_pair_t    nbr_pair;
    degree_t      nbr_degree;
    logic         fv_rd;
    node_id_t     fv_rd_node;
    logic         fv_valid;
    fv_vec_t      fv_beat;
    logic         prev_rd;
    logic         prev_valid;
    agg_vec_t     prev_data;

    pe_bank_if bank_if ();

    // slot keeps the packet until the pe is done with it
    assign wb_packet = task_word;

    task_decode u_decode (
        .clk(clk), .reset(reset), .task_valid(task_valid), .task_packet(task_packet),
        .cur_replay_iter(cur_replay_iter), .take(take), .task_idle(task_idle),
        .task_ready(task_ready), .target(target), .task_word(task_word),
        .include_prev(include_prev), .requeue(requeue)
    );

    neighbor_table u_nbr_table (
        .clk(clk), .reset(reset), .wr_en(nbr_wr_en), .wr_node(nbr_wr_node),
        .wr_degree(nbr_wr_degree), .wr_ids(nbr_wr_ids), .rd(nbr_rd), .rd_node(nbr_rd_node),
        .nbr_sos(nbr_sos), .nbr_eos(nbr_eos), .nbr_pair(nbr_pair), .nbr_degree(nbr_degree)
    );

    feature_table u_fv_table (
        .clk(clk), .reset(reset), .wr_en(fv_wr_en), .wr_node(fv_wr_node),
        .wr_data(fv_wr_data), .rd(fv_rd), .rd_node(fv_rd_node),
        .fv_valid(fv_valid), .fv_data(fv_beat)
    );

    edge_pe u_edge_pe (
        .clk(clk), .reset(reset), .task_ready(task_ready), .target(target),
        .include_prev(include_prev), .requeue(requeue), .take(take),
        .nbr_rd(nbr_rd), .nbr_rd_node(nbr_rd_node), .nbr_sos(nbr_sos), .nbr_eos(nbr_eos),
        .nbr_pair(nbr_pair), .nbr_degree(nbr_degree), .fv_rd(fv_rd), .fv_rd_node(fv_rd_node),
        .fv_valid(fv_valid), .fv_beat(fv_beat), .prev_rd(prev_rd), .prev_valid(prev_valid),
        .prev_data(prev_data), .wb_grant(wb_grant), .wb_valid(wb_valid), .bank(bank_if.pe)
    );

    aggregation_bank u_bank (
        .clk(clk), .reset(reset), .bank(bank_if.bank), .prev_rd(prev_rd),
        .prev_valid(prev_valid), .prev_data(prev_data), .result_valid(result_valid),
        .result_node(result_node), .result_sum(result_sum)
    );

endmodule

// File: rtl/gnn_consts.svh
`ifndef GNN_CONSTS_SVH
`define GNN_CONSTS_SVH

// graph size seen by one aggregation lane
`define GNN_NUM_NODES     128
`define GNN_MAX_DEGREE    8

// two feature lanes per node
`define GNN_FV_LANES      2

// one mask bit per replay iteration
`define GNN_REPLAY_DEPTH  4

`endif

// File: rtl/gnn_pkg.sv
`include "gnn_consts.svh"

package gnn_pkg;

    typedef logic [$clog2(`GNN_NUM_NODES)-1:0]      node_id_t;
    typedef logic [$clog2(`GNN_MAX_DEGREE+1)-1:0]   degree_t;   // 1 to 8
    typedef logic [7:0]                             fv_lane_t;
    typedef logic [11:0]                            agg_lane_t; // wraps mod 4096
    typedef logic [2:0]                             priority_t;
    typedef logic [`GNN_REPLAY_DEPTH-1:0]           replay_mask_t;
    typedef logic [$clog2(`GNN_REPLAY_DEPTH)-1:0]   replay_iter_t;

    // {mask, priority, target}
    typedef logic [$bits(replay_mask_t)+$bits(priority_t)+$bits(node_id_t)-1:0] task_packet_t;

    typedef fv_lane_t  [`GNN_FV_LANES-1:0]   fv_vec_t;
    typedef agg_lane_t [`GNN_FV_LANES-1:0]   agg_vec_t;
    typedef node_id_t  [1:0]                 nbr_pair_t;
    typedef node_id_t  [`GNN_MAX_DEGREE-1:0] nbr_ids_t;

    typedef enum logic [3:0] {
        st_idle,
        st_req_nbr,
        st_stream_nbr,
        st_fetch_fv,
        st_req_prev,
        st_drain,
        st_finish,
        st_complete
    } edge_state_t;

endpackage

// File: rtl/neighbor_table.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module neighbor_table (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  gnn_pkg::node_id_t  wr_node,
    input  gnn_pkg::degree_t   wr_degree,
    input  gnn_pkg::nbr_ids_t  wr_ids,
    input  logic               rd,
    input  gnn_pkg::node_id_t  rd_node,
    output logic               nbr_sos,
    output logic               nbr_eos,
    output gnn_pkg::nbr_pair_t nbr_pair,
    output gnn_pkg::degree_t   nbr_degree
);
    import gnn_pkg::*;

    degree_t    degree_mem [`GNN_NUM_NODES];
    nbr_ids_t   ids_mem    [`GNN_NUM_NODES];
    node_id_t   cur_node;
    logic [1:0] pair_idx;    // next pair to send
    logic       active;
    node_id_t   sel_node;
    logic [1:0] sel_pair;
    degree_t    sel_degree;
    logic       emit;
    logic       last_pair;
    logic       upper_ok;

    assign sel_node   = rd ? rd_node : cur_node;
    assign sel_pair   = rd ? 2'd0 : pair_idx;
    assign sel_degree = degree_mem[sel_node];
    assign emit       = rd || active;
    assign last_pair  = ({1'b0, sel_pair, 1'b0} + 4'd2) >= sel_degree;
    assign upper_ok   = {1'b0, sel_pair, 1'b1} < sel_degree;  // odd tail check

    always_ff @(posedge clk) begin
        if (wr_en) begin
            degree_mem[wr_node] <= wr_degree;
            ids_mem[wr_node]    <= wr_ids;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            nbr_sos <= 1'b0;
            nbr_eos <= 1'b0;
        end else begin
            active  <= emit && !last_pair;
            nbr_sos <= rd;
            nbr_eos <= emit && last_pair;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            cur_node    <= sel_node;
            pair_idx    <= sel_pair + 2'd1;
            nbr_degree  <= sel_degree;
            nbr_pair[0] <= ids_mem[sel_node][{sel_pair, 1'b0}];
            nbr_pair[1] <= upper_ok ? ids_mem[sel_node][{sel_pair, 1'b1}] : '0;
        end
    end

endmodule

// File: rtl/pe_bank_if.sv
`timescale 1ns/1ps

interface pe_bank_if;
    import gnn_pkg::*;

    logic     sos;
    logic     eos;
    agg_vec_t fv_data;   // features arrive zero extended
    node_id_t node_id;   // target of the running task
    logic     done_aggr;
    logic     wb_en;

    modport pe (
        output sos, eos, fv_data, node_id, done_aggr, wb_en
    );

    modport bank (
        input sos, eos, fv_data, node_id, done_aggr, wb_en
    );

endinterface

// File: rtl/task_decode.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module task_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  task_valid,
    input  gnn_pkg::task_packet_t task_packet,
    input  gnn_pkg::replay_iter_t cur_replay_iter,
    input  logic                  take,
    output logic                  task_idle,
    output logic                  task_ready,
    output gnn_pkg::node_id_t     target,
    output gnn_pkg::task_packet_t task_word,
    output logic                  include_prev,
    output logic                  requeue
);
    import gnn_pkg::*;

    replay_mask_t in_mask;
    logic         below;
    logic         above;
    logic         capture;

    assign capture = task_valid && task_idle;
    assign in_mask = task_packet[$bits(task_packet_t)-1 -: $bits(replay_mask_t)];
    assign target  = task_word[$bits(node_id_t)-1:0];

    // mask bits on either side of the current iteration
    always_comb begin
        below = 1'b0;
        above = 1'b0;
        for (int i = 0; i < `GNN_REPLAY_DEPTH; i++) begin
            if (i < int'(cur_replay_iter))
                below |= in_mask[i];
            if (i > int'(cur_replay_iter))
                above |= in_mask[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            task_idle    <= 1'b1;
            task_ready   <= 1'b0;
            include_prev <= 1'b0;
            requeue      <= 1'b0;
        end else if (capture) begin
            task_idle    <= 1'b0;
            task_ready   <= 1'b1;
            include_prev <= below;
            requeue      <= above;
        end else if (take && task_ready) begin
            task_ready <= 1'b0;      // pe picked it up
        end else if (take) begin
            task_idle <= 1'b1;       // pe back in idle
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            task_word <= task_packet;
    end

endmodule

// File: verification/gnn_aggr_tb.sv
`timescale 1ns/1ps
`include "gnn_consts.svh"

module gnn_aggr_tb;
    import gnn_pkg::*;

    localparam int num_tests  = 12;
    localparam int wait_limit = 200;   // cycles per wait

    logic         clk;
    logic         reset;
    logic         task_valid;
    task_packet_t task_packet;
    replay_iter_t cur_replay_iter;
    logic         task_idle;
    logic         nbr_wr_en;
    node_id_t     nbr_wr_node;
    degree_t      nbr_wr_degree;
    nbr_ids_t     nbr_wr_ids;
    logic         fv_wr_en;
    node_id_t     fv_wr_node;
    fv_vec_t      fv_wr_data;
    logic         result_valid;
    node_id_t     result_node;
    agg_vec_t     result_sum;
    logic         wb_valid;
    task_packet_t wb_packet;
    logic         wb_grant;

    // reference copies of the tables
    degree_t  m_degree [`GNN_NUM_NODES];
    nbr_ids_t m_ids    [`GNN_NUM_NODES];
    fv_vec_t  m_feat   [`GNN_NUM_NODES];
    agg_vec_t m_out    [`GNN_NUM_NODES];

    logic [31:0] lfsr = 32'hea7f;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;

    // expect_wb, iteration, mask, node
    logic [13:0] task_table [num_tests] = '{
        {1'b0, 2'd0, 4'b0001, 7'd10},    // degree 1
        {1'b0, 2'd1, 4'b0010, 7'd20},    // degree 2
        {1'b0, 2'd2, 4'b0100, 7'd30},    // degree 7
        {1'b0, 2'd3, 4'b1000, 7'd40},    // degree 8
        {1'b0, 2'd2, 4'b0110, 7'd30},
        {1'b1, 2'd0, 4'b0011, 7'd55},
        {1'b0, 2'd1, 4'b0011, 7'd55},
        {1'b0, 2'd3, 4'b1001, 7'd40},
        {1'b1, 2'd2, 4'b1100, 7'd77},
        {1'b0, 2'd2, 4'b0101, 7'd77},
        {1'b1, 2'd2, 4'b1010, 7'd20},    // write-back that also adds the previous output
        {1'b0, 2'd2, 4'b0101, 7'd20}
    };

    gnn_aggr_top u_dut (
        .clk(clk), .reset(reset), .task_valid(task_valid), .task_packet(task_packet),
        .cur_replay_iter(cur_replay_iter), .task_idle(task_idle),
        .nbr_wr_en(nbr_wr_en), .nbr_wr_node(nbr_wr_node), .nbr_wr_degree(nbr_wr_degree),
        .nbr_wr_ids(nbr_wr_ids), .fv_wr_en(fv_wr_en), .fv_wr_node(fv_wr_node),
        .fv_wr_data(fv_wr_data), .result_valid(result_valid), .result_node(result_node),
        .result_sum(result_sum), .wb_valid(wb_valid), .wb_packet(wb_packet),
        .wb_grant(wb_grant)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic draw(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] time %0t: %s got %0d, expected %0d", $time, what, got, want);
        end
    endtask

    function automatic degree_t pick_degree(input int node, input logic [2:0] rnd);
        case (node)
            10:      return 4'd1;
            20:      return 4'd2;
            30:      return 4'd7;
            40:      return 4'd8;
            default: return {1'b0, rnd} + 4'd1;
        endcase
    endfunction

    task automatic model_sum(input node_id_t node, input logic with_prev, output agg_vec_t sum);
        sum = with_prev ? m_out[node] : '0;
        for (int i = 0; i < int'(m_degree[node]); i++) begin
            for (int l = 0; l < `GNN_FV_LANES; l++) begin
                sum[l] = sum[l] + agg_lane_t'(m_feat[m_ids[node][i]][l]);   // wraps at 4096
            end
        end
    endtask

    task automatic load_tables();
        logic [31:0] r;
        for (int n = 0; n < `GNN_NUM_NODES; n++) begin
            @(negedge clk);
            draw(3, r);
            m_degree[n] = pick_degree(n, r[2:0]);
            for (int i = 0; i < `GNN_MAX_DEGREE; i++) begin
                draw(7, r);
                m_ids[n][i] = r[6:0];
            end
            for (int l = 0; l < `GNN_FV_LANES; l++) begin
                draw(8, r);
                m_feat[n][l] = r[7:0];
            end
            m_out[n]      = '0;
            nbr_wr_en     = 1'b1;
            nbr_wr_node   = node_id_t'(n);
            nbr_wr_degree = m_degree[n];
            nbr_wr_ids    = m_ids[n];
            fv_wr_en      = 1'b1;
            fv_wr_node    = node_id_t'(n);
            fv_wr_data    = m_feat[n];
        end
        @(negedge clk);
        nbr_wr_en = 1'b0;
        fv_wr_en  = 1'b0;
    endtask

    task automatic wait_idle(output logic ok);
        int cnt;
        cnt = 0;
        while (!task_idle && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        ok = task_idle;
        if (!ok)
            $display("task_idle never came back high within %0d cycles", wait_limit);
    endtask

    task automatic wait_end(output logic ok);
        int cnt;
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < wait_limit) begin
            @(negedge clk);
            ok = result_valid || wb_valid;
            cnt++;
        end
        if (!ok)
            $display("neither result_valid nor wb_valid rose within %0d cycles", wait_limit);
    endtask

    task automatic run_test(input int idx, output logic ok);
        node_id_t     node;
        replay_mask_t mask;
        replay_iter_t iter;
        logic         expect_wb;
        logic         with_prev;
        task_packet_t packet;
        agg_vec_t     want;
        logic [31:0]  r;
        int           errors_before;
        int           hold;

        {expect_wb, iter, mask, node} = task_table[idx];
        draw(3, r);
        packet    = {mask, r[2:0], node};   // priority is random
        with_prev = |(mask & ((4'b0001 << iter) - 4'b0001));
        model_sum(node, with_prev, want);
        errors_before = errors;

        wait_idle(ok);
        if (!ok)
            return;
        task_valid      = 1'b1;
        task_packet     = packet;
        cur_replay_iter = iter;
        @(negedge clk);
        task_valid = 1'b0;
        wait_end(ok);
        if (!ok)
            return;

        if (expect_wb) begin
            compare(32'(wb_valid), 32'd1, "wb_valid");
            compare(32'(result_valid), 32'd0, "result_valid on write-back");
            compare(32'(wb_packet), 32'(packet), "wb_packet");
            draw(4, r);
            hold = int'(r[3:0]) + 1;
            for (int c = 0; c < hold; c++) begin
                @(negedge clk);
                compare(32'(wb_valid), 32'd1, "wb_valid without grant");
                compare(32'(result_valid), 32'd0, "result_valid without grant");
                compare(32'(task_idle), 32'd0, "task_idle without grant");
            end
            wb_grant = 1'b1;
            @(negedge clk);
            wb_grant = 1'b0;
            wait_idle(ok);
            if (!ok)
                return;
            compare(32'(wb_valid), 32'd0, "wb_valid after grant");
        end else begin
            compare(32'(result_valid), 32'd1, "result_valid");
            compare(32'(result_node), 32'(node), "result_node");
            compare(32'(result_sum[0]), 32'(want[0]), "result_sum lane 0");
            compare(32'(result_sum[1]), 32'(want[1]), "result_sum lane 1");
        end
        m_out[node] = want;   // stored on both endings
        $display("test %0d node %0d mask %b iter %0d wb %0d: %s", idx, node, mask, iter,
                 expect_wb, (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        logic ok;
        task_valid      = 1'b0;
        task_packet     = '0;
        cur_replay_iter = '0;
        nbr_wr_en       = 1'b0;
        nbr_wr_node     = '0;
        nbr_wr_degree   = '0;
        nbr_wr_ids      = '0;
        fv_wr_en        = 1'b0;
        fv_wr_node      = '0;
        fv_wr_data      = '0;
        wb_grant        = 1'b0;
        reset           = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        compare(32'(task_idle), 32'd1, "task_idle after reset");
        compare(32'(result_valid), 32'd0, "result_valid after reset");
        compare(32'(wb_valid), 32'd0, "wb_valid after reset");
        $display("reset check: %s", (errors == 0) ? "ok" : "mismatch");

        load_tables();
        ok = 1'b1;
        for (int t = 0; t < num_tests && ok; t++) begin
            run_test(t, ok);
            tests_run++;
        end

        $display("tests %0d of %0d, checks %0d, errors %0d", tests_run, num_tests, checks,
                 errors);
        if (ok && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
